/* list.f */
+incdir+.
hsi_pkg.sv
clk_en_gen.sv
tx_arbiter.sv
frame_tx.sv
frame_rx.sv
reply_monitor.sv
line_switch.sv
hsi_master.sv
tb_hsi_master.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_hsi_master
OBJ_DIR   ?= obj_dir
FILE_LIST ?= list.f
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR)

/* tb_hsi_master.sv */
`include "hsi_cfg.svh"

module tb_hsi_master import hsi_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int BIT_DIV     = `HSI_BIT_DIV;
	localparam int FRAME_BITS  = `HSI_FRAME_BITS;
	localparam int FRAME_CYC   = `HSI_FRAME_BITS * `HSI_BIT_DIV;
	localparam int TMO_CYC     = `HSI_REPLY_TIMEOUT * `HSI_BIT_DIV;
	localparam int MAX_CYCLES  = 2 * (6 * 3 * FRAME_CYC + TMO_CYC);
	localparam int MODE_CLEAN  = 0;
	localparam int MODE_PARITY = 1;
	localparam int MODE_SILENT = 2; // Slave does not answer.

	logic       clk;
	logic       n_rst;
	logic       sr_tx_rdy;
	logic       tm_tx_rdy;
	logic       ccw_tx_rdy;
	logic [7:0] ccw_d;
	logic       base_com;
	logic       dat_src;
	logic       dat1;
	logic       dat2;
	logic       sr_tx_ack;
	logic       tm_tx_ack;
	logic       ccw_tx_en;
	logic       ccw_d_sending;
	logic       sr_repeat_req;
	logic       tm_repeat_req;
	logic       ccw_repeat_req;
	logic [7:0] q;
	logic       q_rdy;
	logic [2:0] rx_errs;
	logic       rx_frame_end;
	logic       com1;
	logic       com2;

	integer      seed;
	string       test_name;
	int          err_cnt = 0;
	int          main_err = 0;
	int          test_err_base;
	int          tests_run;
	int          tests_failed;
	int          done_cnt = 0;
	int          cur_mode = MODE_CLEAN;
	src_t        cur_src = SRC_NONE;
	logic [7:0]  exp_reply;
	logic        line_sw = 1'b0; // Line switch model.
	logic        line_flip = 1'b0;
	src_t        exp_src_q[$];
	int          exp_mode_q[$];
	logic [10:0] frame_q[$];
	logic        frame_line_q[$];
	logic        idle_ok_q[$];
	logic        sending_q[$];

	hsi_master uut (.*);

	always #50 clk = ~clk;

	// Bit 11 is the expected line (1 for com2), bits 10:0 the frame, start bit first.
	function automatic logic [11:0] expected_frame(input src_t src, input logic [7:0] ccw_byte,
		input logic base, input logic sw, input logic fl);
		logic [7:0] b;
		case (src)
			SRC_SR:  b = `HSI_SR_CODE;
			SRC_TM:  b = `HSI_TM_CODE;
			default: b = ccw_byte;
		endcase
		return {base ^ (sw & fl), 1'b1, ~^b, b, 1'b0};
	endfunction

	function automatic logic [7:0] rand_byte();
		logic [31:0] r;
		r = $random(seed);
		return r[7:0];
	endfunction

	task automatic send_reply(input logic [7:0] b, input logic bad_par);
		logic [10:0] f;
		f = {1'b1, bad_par ? ^b : ~^b, b, 1'b0};
		for (int i = 0; i < FRAME_BITS; i++)
		begin
			if (dat_src)
				dat2 = f[i];
			else
				dat1 = f[i];
			repeat (BIT_DIV) @(negedge clk);
		end
		dat1 = 1'b1;
		dat2 = 1'b1;
	endtask

	// Slave: decodes each command at bit middles and answers after 4 bit periods.
	initial
	begin : slave
		logic [10:0] bits;
		logic        on_com2;
		logic        idle_ok;
		logic        sending;
		logic [7:0]  rep;
		dat1 = 1'b1;
		dat2 = 1'b1;
		@(posedge n_rst);
		forever
		begin
			@(negedge clk);
			if (com1 === 1'b0 || com2 === 1'b0)
			begin
				on_com2 = (com1 !== 1'b0);
				idle_ok = 1'b1;
				repeat (BIT_DIV / 2) @(negedge clk);
				sending = ccw_d_sending;
				for (int i = 0; i < FRAME_BITS; i++)
				begin
					if (i > 0)
						repeat (BIT_DIV) @(negedge clk);
					bits[i] = on_com2 ? com2 : com1;
					if ((on_com2 ? com1 : com2) !== 1'b1)
						idle_ok = 1'b0;
				end
				frame_q.push_back(bits);
				frame_line_q.push_back(on_com2);
				idle_ok_q.push_back(idle_ok);
				sending_q.push_back(sending);
				if (cur_mode != MODE_SILENT)
				begin
					rep = rand_byte();
					if (cur_mode == MODE_CLEAN)
						exp_reply = rep;
					repeat (4 * BIT_DIV) @(negedge clk);
					send_reply(rep, cur_mode == MODE_PARITY);
				end
			end
		end
	end

	always @(negedge clk)
	begin : compare
		src_t        ack_src;
		src_t        want_src;
		src_t        rep_src;
		logic [11:0] want;
		logic [10:0] frm;
		logic        frm_line;
		logic        idle_ok;
		logic        sending;
		logic [2:0]  want_errs;
		if (n_rst)
		begin
			if (sr_tx_ack || tm_tx_ack || ccw_tx_en)
			begin
				ack_src = sr_tx_ack ? SRC_SR : (tm_tx_ack ? SRC_TM : SRC_CCW);
				assert (exp_src_q.size() > 0)
				else
				begin
					$display("[ERROR] %s: ack for %s with no command pending",
						test_name, ack_src.name());
					err_cnt++;
				end
				if (exp_src_q.size() > 0)
				begin
					want_src = exp_src_q.pop_front();
					cur_mode = exp_mode_q.pop_front();
					cur_src  = ack_src;
					assert (ack_src == want_src)
					else
					begin
						$display("[ERROR] %s: granted source expected %s actual %s",
							test_name, want_src.name(), ack_src.name());
						err_cnt++;
					end
				end
			end
			if (frame_q.size() > 0)
			begin
				frm      = frame_q.pop_front();
				frm_line = frame_line_q.pop_front();
				idle_ok  = idle_ok_q.pop_front();
				sending  = sending_q.pop_front();
				want     = expected_frame(cur_src, ccw_d, base_com, line_sw, line_flip);
				assert (frm == want[10:0])
				else
				begin
					$display("[ERROR] %s: command frame expected %h actual %h",
						test_name, want[10:0], frm);
					err_cnt++;
				end
				assert (frm_line == want[11])
				else
				begin
					$display("[ERROR] %s: command line expected com%0d actual com%0d",
						test_name, want[11] + 1, frm_line + 1);
					err_cnt++;
				end
				assert (idle_ok)
				else
				begin
					$display("[ERROR] %s: the unused line did not stay idle during a frame",
						test_name);
					err_cnt++;
				end
				assert (sending == (cur_src == SRC_CCW))
				else
				begin
					$display("[ERROR] %s: ccw_d_sending expected %b actual %b",
						test_name, cur_src == SRC_CCW, sending);
					err_cnt++;
				end
			end
			if (rx_frame_end)
			begin
				want_errs = 3'b000;
				if (cur_mode == MODE_PARITY)
					want_errs[RX_ERR_PARITY] = 1'b1;
				assert (rx_errs == want_errs)
				else
				begin
					$display("[ERROR] %s: rx_errs expected %b actual %b",
						test_name, want_errs, rx_errs);
					err_cnt++;
				end
				assert (cur_mode != MODE_SILENT)
				else
				begin
					$display("[ERROR] %s: reply frame ended while the slave was silent",
						test_name);
					err_cnt++;
				end
				if (cur_mode == MODE_CLEAN)
					line_sw = 1'b0; // A good reply ends the switch.
			end
			if (q_rdy)
			begin
				assert (cur_mode == MODE_CLEAN)
				else
				begin
					$display("[ERROR] %s: q_rdy after a bad or missing reply", test_name);
					err_cnt++;
				end
				assert (q == exp_reply)
				else
				begin
					$display("[ERROR] %s: q expected %h actual %h", test_name, exp_reply, q);
					err_cnt++;
				end
				done_cnt++;
			end
			if (sr_repeat_req || tm_repeat_req || ccw_repeat_req)
			begin
				rep_src = sr_repeat_req ? SRC_SR : (tm_repeat_req ? SRC_TM : SRC_CCW);
				assert (cur_mode != MODE_CLEAN)
				else
				begin
					$display("[ERROR] %s: repeat request after a clean reply", test_name);
					err_cnt++;
				end
				assert (rep_src == cur_src)
				else
				begin
					$display("[ERROR] %s: repeat source expected %s actual %s",
						test_name, cur_src.name(), rep_src.name());
					err_cnt++;
				end
				if (cur_mode == MODE_SILENT)
				begin
					if (!line_sw)
						line_flip = ~line_flip; // Toggles as the switch engages.
					line_sw = 1'b1;
				end
				done_cnt++;
			end
		end
	end

	task automatic wait_done(input int target);
		while (done_cnt < target)
		begin
			@(negedge clk);
			if (sr_tx_ack)
				sr_tx_rdy = 1'b0;
			if (tm_tx_ack)
				tm_tx_rdy = 1'b0;
			if (ccw_tx_en)
				ccw_tx_rdy = 1'b0;
		end
		repeat (4) @(negedge clk); // Room for a stray repeat pulse.
	endtask

	task automatic run_cmd(input src_t src, input int mode);
		int target;
		target = done_cnt + 1;
		exp_src_q.push_back(src);
		exp_mode_q.push_back(mode);
		case (src)
			SRC_SR:  sr_tx_rdy = 1'b1;
			SRC_TM:  tm_tx_rdy = 1'b1;
			default: ccw_tx_rdy = 1'b1;
		endcase
		wait_done(target);
	endtask

	task automatic begin_test(input string name);
		test_name     = name;
		test_err_base = err_cnt + main_err;
	endtask

	task automatic finish_test();
		int errs;
		assert (exp_src_q.size() == 0 && frame_q.size() == 0)
		else
		begin
			$display("[ERROR] %s: a command was never granted or its frame never checked",
				test_name);
			main_err++;
		end
		errs = err_cnt + main_err - test_err_base;
		tests_run++;
		if (errs == 0)
			$display("test %-14s ok", test_name);
		else
		begin
			tests_failed++;
			$display("test %-14s failed with %0d errors", test_name, errs);
		end
	endtask

	initial
	begin : watchdog
		int cycles;
		cycles = 0;
		while (cycles < MAX_CYCLES)
		begin
			@(posedge clk);
			cycles++;
		end
		$display("Run stopped after %0d cycles, the link hung in test %s",
			MAX_CYCLES, test_name);
		$display("TEST FAILED");
		$finish;
	end

	initial
	begin
		int target;
		seed       = 94195;
		clk        = 1'b0;
		n_rst      = 1'b0;
		sr_tx_rdy  = 1'b0;
		tm_tx_rdy  = 1'b0;
		ccw_tx_rdy = 1'b0;
		ccw_d      = 8'h00;
		base_com   = 1'b0;
		dat_src    = 1'b0;
		test_name  = "reset";
		tests_run  = 0;
		tests_failed = 0;
		repeat (2) @(negedge clk);
		n_rst = 1'b1;
		repeat (2) @(negedge clk);

		begin_test("ccw_com1");
		ccw_d = rand_byte();
		run_cmd(SRC_CCW, MODE_CLEAN);
		finish_test();

		begin_test("ccw_com2");
		base_com = 1'b1;
		ccw_d    = rand_byte();
		run_cmd(SRC_CCW, MODE_CLEAN);
		finish_test();

		begin_test("priority");
		base_com = 1'b0;
		ccw_d    = rand_byte();
		target   = done_cnt + 3;
		exp_src_q.push_back(SRC_SR);
		exp_src_q.push_back(SRC_TM);
		exp_src_q.push_back(SRC_CCW);
		repeat (3) exp_mode_q.push_back(MODE_CLEAN);
		sr_tx_rdy  = 1'b1;
		tm_tx_rdy  = 1'b1;
		ccw_tx_rdy = 1'b1;
		wait_done(target);
		finish_test();

		begin_test("clean_dat2");
		dat_src = 1'b1;
		run_cmd(SRC_TM, MODE_CLEAN);
		finish_test();

		begin_test("parity_error");
		run_cmd(SRC_SR, MODE_PARITY);
		run_cmd(SRC_SR, MODE_CLEAN); // Resend stays on the base line.
		finish_test();

		begin_test("no_reply");
		dat_src = 1'b0;
		ccw_d   = rand_byte();
		run_cmd(SRC_CCW, MODE_SILENT);
		run_cmd(SRC_CCW, MODE_CLEAN);
		run_cmd(SRC_TM, MODE_CLEAN);
		finish_test();

		$display("tests: %0d run, %0d failed, %0d errors",
			tests_run, tests_failed, err_cnt + main_err);
		if (tests_failed == 0 && err_cnt + main_err == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

/* hsi_master.sv */
module hsi_master import hsi_pkg::*;
(
	input  logic       clk,
	input  logic       n_rst,
	input  logic       sr_tx_rdy,
	input  logic       tm_tx_rdy,
	input  logic       ccw_tx_rdy,
	input  logic [7:0] ccw_d,
	input  logic       base_com,
	input  logic       dat_src,
	input  logic       dat1,
	input  logic       dat2,
	output logic       sr_tx_ack,
	output logic       tm_tx_ack,
	output logic       ccw_tx_en,
	output logic       ccw_d_sending,
	output logic       sr_repeat_req,
	output logic       tm_repeat_req,
	output logic       ccw_repeat_req,
	output logic [7:0] q,
	output logic       q_rdy,
	output logic [2:0] rx_errs,
	output logic       rx_frame_end,
	output logic       com1,
	output logic       com2
);

	logic       tx_bit_en;
	logic       tx_start;
	logic [7:0] tx_byte;
	src_t       grant_src;
	logic       tx_bit;
	logic       tx_busy;
	logic       tx_done;
	logic       reply_wait;
	logic       rx_start;
	logic       switch_req;
	logic       reply_ok;

	clk_en_gen u_clk_en (.clk(clk), .n_rst(n_rst), .tx_bit_en(tx_bit_en));

	tx_arbiter u_arb (
		.clk(clk), .n_rst(n_rst),
		.sr_tx_rdy(sr_tx_rdy), .tm_tx_rdy(tm_tx_rdy), .ccw_tx_rdy(ccw_tx_rdy),
		.ccw_d(ccw_d), .tx_busy(tx_busy), .reply_wait(reply_wait),
		.sr_tx_ack(sr_tx_ack), .tm_tx_ack(tm_tx_ack), .ccw_tx_en(ccw_tx_en),
		.tx_start(tx_start), .tx_byte(tx_byte), .grant_src(grant_src)
	);

	frame_tx u_tx (
		.clk(clk), .n_rst(n_rst), .tx_bit_en(tx_bit_en),
		.tx_start(tx_start), .tx_byte(tx_byte), .grant_src(grant_src),
		.tx_bit(tx_bit), .tx_busy(tx_busy), .tx_done(tx_done),
		.ccw_d_sending(ccw_d_sending)
	);

	frame_rx u_rx (
		.clk(clk), .n_rst(n_rst), .dat1(dat1), .dat2(dat2), .dat_src(dat_src),
		.q(q), .q_rdy(q_rdy), .rx_start(rx_start),
		.rx_frame_end(rx_frame_end), .rx_errs(rx_errs)
	);

	reply_monitor u_mon (
		.clk(clk), .n_rst(n_rst), .tx_start(tx_start), .tx_done(tx_done),
		.grant_src(grant_src), .rx_start(rx_start),
		.rx_frame_end(rx_frame_end), .rx_errs(rx_errs),
		.reply_wait(reply_wait), .sr_repeat_req(sr_repeat_req),
		.tm_repeat_req(tm_repeat_req), .ccw_repeat_req(ccw_repeat_req),
		.switch_req(switch_req), .reply_ok(reply_ok)
	);

	line_switch u_line (
		.clk(clk), .n_rst(n_rst), .switch_req(switch_req), .reply_ok(reply_ok),
		.base_com(base_com), .tx_bit(tx_bit), .com1(com1), .com2(com2)
	);

endmodule

/* line_switch.sv */
module line_switch
(
	input  logic clk,
	input  logic n_rst,
	input  logic switch_req,
	input  logic reply_ok,
	input  logic base_com,
	input  logic tx_bit,
	output logic com1,
	output logic com2
);

	logic switched;
	logic flip;
	logic use_com2;

	assign use_com2 = base_com ^ (switched & flip);
	assign com1     = use_com2 ? 1'b1 : tx_bit;
	assign com2     = use_com2 ? tx_bit : 1'b1;

	always_ff @(posedge clk or negedge n_rst)
	begin
		if (!n_rst)
		begin
			switched <= 1'b0;
			flip     <= 1'b0;
		end
		else
		begin
			if (switch_req && !switched)
				flip <= ~flip; // Rising edge of switched.
			if (switch_req)
				switched <= 1'b1;
			else if (reply_ok)
				switched <= 1'b0;
		end
	end

endmodule

/* reply_monitor.sv */
`include "hsi_cfg.svh"

module reply_monitor import hsi_pkg::*;
(
	input  logic       clk,
	input  logic       n_rst,
	input  logic       tx_start,
	input  logic       tx_done,
	input  src_t       grant_src,
	input  logic       rx_start,
	input  logic       rx_frame_end,
	input  logic [2:0] rx_errs,
	output logic       reply_wait,
	output logic       sr_repeat_req,
	output logic       tm_repeat_req,
	output logic       ccw_repeat_req,
	output logic       switch_req,
	output logic       reply_ok
);

	localparam int LIMIT = `HSI_REPLY_TIMEOUT * `HSI_BIT_DIV;
	localparam int CNT_W = $clog2(LIMIT);

	logic             wait_q;
	logic             timing; // Between tx_done and the reply start bit.
	logic [CNT_W-1:0] tmo_cnt;
	logic             timeout;
	logic             bad_reply;
	logic             fail;

	assign reply_wait = wait_q | tx_start;
	assign timeout    = timing & (tmo_cnt == CNT_W'(LIMIT - 1));
	assign bad_reply  = wait_q & rx_frame_end & (|rx_errs);
	assign fail       = timeout | bad_reply;

	always_ff @(posedge clk or negedge n_rst)
	begin
		if (!n_rst)
		begin
			wait_q         <= 1'b0;
			timing         <= 1'b0;
			tmo_cnt        <= '0;
			sr_repeat_req  <= 1'b0;
			tm_repeat_req  <= 1'b0;
			ccw_repeat_req <= 1'b0;
			switch_req     <= 1'b0;
			reply_ok       <= 1'b0;
		end
		else
		begin
			sr_repeat_req  <= fail && (grant_src == SRC_SR);
			tm_repeat_req  <= fail && (grant_src == SRC_TM);
			ccw_repeat_req <= fail && (grant_src == SRC_CCW);
			switch_req     <= timeout; // Only silence moves the line.
			reply_ok       <= wait_q & rx_frame_end & ~(|rx_errs);
			if (tx_start)
			begin
				wait_q <= 1'b1;
				timing <= 1'b0;
			end
			else if (timeout || (wait_q && rx_frame_end))
			begin
				wait_q <= 1'b0;
				timing <= 1'b0;
			end
			else if (wait_q && tx_done)
			begin
				timing  <= 1'b1;
				tmo_cnt <= '0;
			end
			else if (rx_start)
				timing <= 1'b0;
			else if (timing)
				tmo_cnt <= tmo_cnt + 1'b1;
		end
	end

endmodule

/* frame_rx.sv */
`include "hsi_cfg.svh"

module frame_rx import hsi_pkg::*;
(
	input  logic       clk,
	input  logic       n_rst,
	input  logic       dat1,
	input  logic       dat2,
	input  logic       dat_src,
	output logic [7:0] q,
	output logic       q_rdy,
	output logic       rx_start,
	output logic       rx_frame_end,
	output logic [2:0] rx_errs
);

	localparam int OVS  = `HSI_RX_OVS;
	localparam int PH_W = $clog2(OVS);

	logic [2:0]      sync; // Two sync flops, then the previous sample.
	logic            line;
	logic            fall;
	logic            in_start;
	logic            in_bits;
	logic [PH_W-1:0] phase;
	logic [3:0]      bit_idx;
	logic [7:0]      data_sr;
	logic            par_bit;
	logic            bit_mid;

	assign line    = sync[1];
	assign fall    = sync[2] & ~sync[1];
	assign bit_mid = in_bits && (phase == PH_W'(OVS - 1));

	always_ff @(posedge clk or negedge n_rst)
	begin
		if (!n_rst)
			sync <= '1;
		else
			sync <= {sync[1:0], dat_src ? dat2 : dat1};
	end

	always_ff @(posedge clk)
	begin
		if (bit_mid)
		begin
			if (bit_idx < 4'd8)
				data_sr <= {line, data_sr[7:1]};
			else if (bit_idx == 4'd8)
				par_bit <= line;
			else
				q <= data_sr;
		end
	end

	always_ff @(posedge clk or negedge n_rst)
	begin
		if (!n_rst)
		begin
			in_start     <= 1'b0;
			in_bits      <= 1'b0;
			phase        <= '0;
			bit_idx      <= '0;
			rx_errs      <= '0;
			rx_start     <= 1'b0;
			rx_frame_end <= 1'b0;
			q_rdy        <= 1'b0;
		end
		else
		begin
			rx_start     <= 1'b0;
			rx_frame_end <= 1'b0;
			q_rdy        <= 1'b0;
			phase        <= phase + 1'b1;
			if (!in_start && !in_bits)
			begin
				if (fall)
				begin
					in_start <= 1'b1;
					phase    <= '0;
					rx_errs  <= '0; // Errors of the last frame held until here.
				end
			end
			else if (in_start)
			begin
				if (phase == PH_W'(OVS / 2 - 1))
				begin
					in_start <= 1'b0;
					phase    <= '0;
					if (!line)
					begin
						in_bits  <= 1'b1;
						bit_idx  <= '0;
						rx_start <= 1'b1;
					end
					else
					begin
						rx_errs[RX_ERR_START] <= 1'b1; // Glitch.
						rx_frame_end          <= 1'b1;
					end
				end
			end
			else if (bit_mid)
			begin
				phase   <= '0;
				bit_idx <= bit_idx + 1'b1;
				if (bit_idx == 4'd9)
				begin
					in_bits                <= 1'b0;
					rx_frame_end           <= 1'b1;
					rx_errs[RX_ERR_PARITY] <= ~(^{par_bit, data_sr});
					rx_errs[RX_ERR_STOP]   <= ~line;
					q_rdy                  <= (^{par_bit, data_sr}) & line;
				end
			end
		end
	end

endmodule

/* frame_tx.sv */
`include "hsi_cfg.svh"

module frame_tx import hsi_pkg::*;
(
	input  logic       clk,
	input  logic       n_rst,
	input  logic       tx_bit_en,
	input  logic       tx_start,
	input  logic [7:0] tx_byte,
	input  src_t       grant_src,
	output logic       tx_bit,
	output logic       tx_busy,
	output logic       tx_done,
	output logic       ccw_d_sending
);

	localparam int FRAME_BITS = `HSI_FRAME_BITS;

	logic [FRAME_BITS-1:0] shreg;
	logic [3:0]            bit_cnt;
	logic                  pending; // Frame loaded, waiting for a bit boundary.
	logic                  active;
	logic                  is_ccw;

	assign tx_busy       = pending | active;
	assign tx_done       = active & tx_bit_en & (bit_cnt == 4'(FRAME_BITS - 1));
	assign ccw_d_sending = active & is_ccw;

	// Stop, odd parity, data LSB first, start.
	always_ff @(posedge clk)
	begin
		if (tx_start)
			shreg <= {1'b1, ~^tx_byte, tx_byte, 1'b0};
		else if (tx_bit_en && tx_busy)
			shreg <= {1'b1, shreg[FRAME_BITS-1:1]};
	end

	always_ff @(posedge clk or negedge n_rst)
	begin
		if (!n_rst)
		begin
			tx_bit  <= 1'b1;
			bit_cnt <= '0;
			pending <= 1'b0;
			active  <= 1'b0;
			is_ccw  <= 1'b0;
		end
		else if (tx_start)
		begin
			pending <= 1'b1;
			is_ccw  <= (grant_src == SRC_CCW);
		end
		else if (tx_bit_en)
		begin
			if (pending)
			begin
				pending <= 1'b0;
				active  <= 1'b1;
				bit_cnt <= '0;
				tx_bit  <= shreg[0]; // Start bit.
			end
			else if (tx_done)
			begin
				active <= 1'b0;
				tx_bit <= 1'b1; // Back to idle.
			end
			else if (active)
			begin
				bit_cnt <= bit_cnt + 1'b1;
				tx_bit  <= shreg[0];
			end
		end
	end

endmodule

/* tx_arbiter.sv */
`include "hsi_cfg.svh"

module tx_arbiter import hsi_pkg::*;
(
	input  logic       clk,
	input  logic       n_rst,
	input  logic       sr_tx_rdy,
	input  logic       tm_tx_rdy,
	input  logic       ccw_tx_rdy,
	input  logic [7:0] ccw_d,
	input  logic       tx_busy,
	input  logic       reply_wait,
	output logic       sr_tx_ack,
	output logic       tm_tx_ack,
	output logic       ccw_tx_en,
	output logic       tx_start,
	output logic [7:0] tx_byte,
	output src_t       grant_src
);

	src_t pick;
	logic grant_ok;

	always_comb
	begin
		pick = SRC_NONE;
		if (sr_tx_rdy)
			pick = SRC_SR; // Service request wins.
		else if (tm_tx_rdy)
			pick = SRC_TM;
		else if (ccw_tx_rdy)
			pick = SRC_CCW;
	end

	// tx_start guards the cycle before tx_busy rises.
	assign grant_ok = (pick != SRC_NONE) && !tx_busy && !reply_wait && !tx_start;

	always_ff @(posedge clk or negedge n_rst)
	begin
		if (!n_rst)
		begin
			tx_start  <= 1'b0;
			sr_tx_ack <= 1'b0;
			tm_tx_ack <= 1'b0;
			ccw_tx_en <= 1'b0;
			grant_src <= SRC_NONE;
		end
		else
		begin
			tx_start  <= grant_ok;
			sr_tx_ack <= grant_ok && (pick == SRC_SR);
			tm_tx_ack <= grant_ok && (pick == SRC_TM);
			ccw_tx_en <= grant_ok && (pick == SRC_CCW);
			if (grant_ok)
				grant_src <= pick; // Held for reply supervision.
		end
	end

	always_ff @(posedge clk)
	begin
		if (grant_ok)
		begin
			case (pick)
				SRC_SR:  tx_byte <= `HSI_SR_CODE;
				SRC_TM:  tx_byte <= `HSI_TM_CODE;
				default: tx_byte <= ccw_d;
			endcase
		end
	end

endmodule

/* clk_en_gen.sv */
`include "hsi_cfg.svh"

module clk_en_gen
(
	input  logic clk,
	input  logic n_rst,
	output logic tx_bit_en
);

	localparam int DIV   = `HSI_BIT_DIV;
	localparam int CNT_W = $clog2(DIV);

	logic [CNT_W-1:0] div_cnt;

	assign tx_bit_en = (div_cnt == CNT_W'(DIV - 1)); // One clk per bit period.

	always_ff @(posedge clk or negedge n_rst)
	begin
		if (!n_rst)
			div_cnt <= '0;
		else if (tx_bit_en)
			div_cnt <= '0;
		else
			div_cnt <= div_cnt + 1'b1;
	end

endmodule

/* hsi_pkg.sv */
package hsi_pkg;

	// Source of the command currently on the link.
	typedef enum logic [1:0]
	{
		SRC_NONE = 2'd0,
		SRC_SR   = 2'd1,
		SRC_TM   = 2'd2,
		SRC_CCW  = 2'd3
	} src_t;

	localparam int RX_ERR_START  = 0; // Start bit not low at its middle.
	localparam int RX_ERR_PARITY = 1;
	localparam int RX_ERR_STOP   = 2; // Stop bit sampled low.

endpackage

/* hsi_cfg.svh */
`ifndef HSI_CFG_SVH
`define HSI_CFG_SVH

// Serial timing.
`define HSI_BIT_DIV 4
`define HSI_RX_OVS 4
`define HSI_FRAME_BITS 11

// Fixed command bytes.
`define HSI_SR_CODE 8'hA5
`define HSI_TM_CODE 8'h3C

// Bit periods allowed between stop bit and reply start bit.
`define HSI_REPLY_TIMEOUT 24

`endif
